// ==== fbwg_frame.f ====
logic/fbwg_pkg.sv
logic/key_arbiter.sv
logic/play_timer.sv
logic/sound_select.sv
logic/fbwg_frame_top.sv
tests/fbwg_frame_checker.sv
tests/fbwg_frame_tb.sv

// ==== tests/fbwg_frame_tb.sv ====
`default_nettype none

module fbwg_frame_tb
    import fbwg_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned FPS          = 4;
    localparam int unsigned MIN_LIMIT    = 1;
    localparam int unsigned KEY_REPORTS  = 16;
    localparam int unsigned AUDIO_STEPS  = 24;
    localparam int unsigned QUIET_CYCLES = 20;
    // about 350 cycles of tests, the rest is margin
    localparam int unsigned CYCLE_LIMIT  = 600;

    logic          vsync;
    logic          reset_ah;
    keycode_word_t keycode_i;
    logic          keycode_stb_i;
    logic          mute_i;
    logic          game_won_i;
    logic          game_lost_i;
    player_keys_t  keys_o;
    audio_sel_t    audio_sel_o;
    play_time_t    time_o;
    logic          time_stb_o;

    int unsigned cycle_count;
    int unsigned release_cycle;
    int unsigned error_count;
    int unsigned test_errors;
    int unsigned tests_passed;
    int unsigned tests_failed;
    string       test_name;
    play_time_t  ref_time;
    key_t        key_pool [0:11];

    fbwg_frame_top #(
        .FRAMES_PER_SEC (FPS),
        .MINUTES_LIMIT  (MIN_LIMIT)
    ) UUT (
        .vsync         (vsync),
        .reset_ah      (reset_ah),
        .keycode_i     (keycode_i),
        .keycode_stb_i (keycode_stb_i),
        .mute_i        (mute_i),
        .game_won_i    (game_won_i),
        .game_lost_i   (game_lost_i),
        .keys_o        (keys_o),
        .audio_sel_o   (audio_sel_o),
        .time_o        (time_o),
        .time_stb_o    (time_stb_o)
    );

    always #4 vsync = ~vsync;

    always @(posedge vsync)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // compare tasks and bookkeeping
    // ------------------------------------------------------------------------

    task automatic check_keys(input player_keys_t exp, input player_keys_t act);
        if (act !== exp)
        begin
            $display("FAIL %s: keys expected water=%h fire=%h, actual water=%h fire=%h",
                     test_name, exp.water, exp.fire, act.water, act.fire);
            error_count++;
        end
    endtask

    task automatic check_time(input play_time_t exp, input play_time_t act);
        if (act !== exp)
        begin
            $display("FAIL %s: time expected %0d:%0d%0d, actual %0d:%0d%0d", test_name,
                     exp.minutes, exp.tens, exp.units, act.minutes, act.tens, act.units);
            error_count++;
        end
    endtask

    task automatic check_audio(input audio_sel_t exp, input audio_sel_t act);
        if (act !== exp)
        begin
            $display("FAIL %s: audio expected %0d, actual %0d", test_name, exp, act);
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = error_count;
    endtask

    task automatic end_test();
        if (error_count == test_errors)
        begin
            tests_passed++;
            $display("%s: ok", test_name);
        end
        else
        begin
            tests_failed++;
            $display("%s: %0d errors", test_name, error_count - test_errors);
        end
    endtask

    // reset seen by the DUT on two edges, ends on a falling edge
    task automatic apply_reset();
        @(posedge vsync);
        reset_ah <= 1'b1;
        repeat (2) @(posedge vsync);
        reset_ah <= 1'b0;
        @(negedge vsync);
        release_cycle = cycle_count;
    endtask

    // ------------------------------------------------------------------------
    // reference rules
    // ------------------------------------------------------------------------

    // top byte is scanned first, the two players search independently
    function automatic player_keys_t first_keys(input keycode_word_t word);
        player_keys_t found;
        key_t         k;
        found = {KEY_NONE, KEY_NONE};
        for (int b = 3; b >= 0; b--)
        begin
            k = word[8*b +: 8];
            if (found.water == KEY_NONE &&
                (k == KEY_W || k == KEY_S || k == KEY_A || k == KEY_D))
                found.water = k;
            if (found.fire == KEY_NONE &&
                (k == KEY_UP || k == KEY_DOWN || k == KEY_LEFT || k == KEY_RIGHT))
                found.fire = k;
        end
        return found;
    endfunction

    function automatic audio_sel_t audio_rule(input logic mute, input logic won,
                                              input logic lost, input logic time_out);
        if (mute)
            return AUDIO_MUTE;
        else if (won)
            return AUDIO_WIN;
        else if (lost || time_out)
            return AUDIO_FAIL;
        else
            return AUDIO_BGM;
    endfunction

    function automatic play_time_t next_time(input play_time_t t);
        play_time_t n;
        n = t;
        if (t.units < 9)
            n.units = t.units + 1;
        else
        begin
            n.units = 0;
            if (t.tens < 5)
                n.tens = t.tens + 1;
            else
            begin
                n.tens    = 0;
                n.minutes = (t.minutes == MIN_LIMIT - 1) ? 4'd0 : t.minutes + 1;
            end
        end
        return n;
    endfunction

    // ------------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------------

    task automatic test_reset_state();
        start_test("reset_state");
        apply_reset();
        check_keys({KEY_NONE, KEY_NONE}, keys_o);
        check_time('0, time_o);
        check_audio(AUDIO_BGM, audio_sel_o);
        if (time_stb_o !== 1'b0)
        begin
            $display("%s: time_stb_o is not low after reset", test_name);
            error_count++;
        end
        end_test();
    endtask

    task automatic test_key_arbitration();
        keycode_word_t word;
        player_keys_t  expected;
        start_test("key_arbitration");
        for (int r = 0; r < KEY_REPORTS; r++)
        begin
            word = {key_pool[$urandom % 12], key_pool[$urandom % 12],
                    key_pool[$urandom % 12], key_pool[$urandom % 12]};
            expected = first_keys(word);
            @(posedge vsync);
            keycode_i     <= word;
            keycode_stb_i <= 1'b1;
            @(posedge vsync);
            keycode_stb_i <= 1'b0;
            keycode_i     <= $urandom;
            @(negedge vsync);
            check_keys(expected, keys_o);
            // other report bits without a strobe
            @(posedge vsync);
            @(negedge vsync);
            check_keys(expected, keys_o);
        end
        end_test();
    endtask

    task automatic test_audio_priority();
        logic [2:0] stim;
        logic [2:0] prev;
        start_test("audio_priority");
        prev = 3'b000;
        for (int i = 0; i <= AUDIO_STEPS; i++)
        begin
            stim = {1'(($urandom % 4) == 0), 1'($urandom), 1'($urandom)};
            @(posedge vsync);
            mute_i      <= stim[2];
            game_won_i  <= stim[1];
            game_lost_i <= stim[0];
            @(negedge vsync);
            // this edge registered the previous step
            check_audio(audio_rule(prev[2], prev[1], prev[0], 1'b0), audio_sel_o);
            prev = stim;
        end
        @(posedge vsync);
        mute_i      <= 1'b0;
        game_won_i  <= 1'b0;
        game_lost_i <= 1'b0;
        @(negedge vsync);
        // last random step
        check_audio(audio_rule(prev[2], prev[1], prev[0], 1'b0), audio_sel_o);
        end_test();
    endtask

    // counts 0:01 up to 0:59, the tens carry included
    task automatic test_time_counting();
        int unsigned changes;
        int unsigned since;
        start_test("time_counting");
        apply_reset();
        ref_time = '0;
        changes  = 0;
        while (changes < 60 * MIN_LIMIT - 1)
        begin
            @(negedge vsync);
            if (time_stb_o)
            begin
                changes++;
                since = cycle_count - release_cycle;
                if (since != changes * FPS + 1)
                begin
                    $display("%s: change %0d came %0d cycles after reset instead of %0d",
                             test_name, changes, since, changes * FPS + 1);
                    error_count++;
                end
                ref_time = next_time(ref_time);
                check_time(ref_time, time_o);
            end
        end
        end_test();
    endtask

    task automatic test_expiry();
        int unsigned since;
        start_test("expiry");
        @(negedge vsync);
        while (!time_stb_o)
            @(negedge vsync);
        since = cycle_count - release_cycle;
        if (since != 60 * MIN_LIMIT * FPS + 1)
        begin
            $display("%s: last change came %0d cycles after reset", test_name, since);
            error_count++;
        end
        // minute limit wraps the display back to 0:00
        ref_time = next_time(ref_time);
        check_time(ref_time, time_o);
        check_audio(AUDIO_FAIL, audio_sel_o);
        repeat (QUIET_CYCLES)
        begin
            @(negedge vsync);
            if (time_stb_o)
            begin
                $display("%s: time_stb_o pulsed after the time ran out", test_name);
                error_count++;
            end
        end
        check_time(ref_time, time_o);
        check_audio(AUDIO_FAIL, audio_sel_o);
        end_test();
    endtask

    initial
    begin
        void'($urandom(22));
        vsync         = 1'b0;
        reset_ah      = 1'b1;
        keycode_i     = '0;
        keycode_stb_i = 1'b0;
        mute_i        = 1'b0;
        game_won_i    = 1'b0;
        game_lost_i   = 1'b0;
        cycle_count   = 0;
        error_count   = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        // movement keys, no key and a few unrelated ones
        key_pool = '{KEY_W, KEY_S, KEY_A, KEY_D, KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT,
                     KEY_NONE, 8'h2C, 8'h28, 8'h1E};

        test_reset_state();
        test_key_arbitration();
        test_audio_priority();
        test_time_counting();
        test_expiry();

        $display("tests passed: %0d, tests failed: %0d, assertion failures: %0d",
                 tests_passed, tests_failed, UUT.frame_checker_i.fail_count);
        if (error_count == 0 && UUT.frame_checker_i.fail_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/fbwg_frame_checker.sv ====
`default_nettype none

module fbwg_frame_checker
    import fbwg_pkg::*;
(
    input logic       vsync,
    input logic       reset_ah,
    input logic       mute_i,
    input audio_sel_t audio_sel_o,
    input play_time_t time_o,
    input logic       time_stb_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // assertion failures so far
    int unsigned fail_count = 0;

    // at most one time change per frame pair
    stb_single_a: assert property (
        @(posedge vsync) disable iff (reset_ah)
        time_stb_o |=> !time_stb_o
    ) else
    begin
        fail_count++;
        $error("time_stb_o high in two consecutive cycles");
    end

    // mute wins one register stage later
    mute_wins_a: assert property (
        @(posedge vsync) disable iff (reset_ah)
        mute_i |=> (audio_sel_o == AUDIO_MUTE)
    ) else
    begin
        fail_count++;
        $error("audio_sel_o not AUDIO_MUTE one cycle after mute_i");
    end

    // display time only moves together with its strobe
    time_stable_a: assert property (
        @(posedge vsync) disable iff (reset_ah)
        !time_stb_o |-> $stable(time_o)
    ) else
    begin
        fail_count++;
        $error("time_o changed without time_stb_o");
    end

endmodule

bind fbwg_frame_top fbwg_frame_checker frame_checker_i (
    .vsync       (vsync),
    .reset_ah    (reset_ah),
    .mute_i      (mute_i),
    .audio_sel_o (audio_sel_o),
    .time_o      (time_o),
    .time_stb_o  (time_stb_o)
);

`default_nettype wire

// ==== logic/fbwg_frame_top.sv ====
`default_nettype none

module fbwg_frame_top
    import fbwg_pkg::*;
#(
    parameter int unsigned FRAMES_PER_SEC = 61,
    parameter int unsigned MINUTES_LIMIT  = 5
)
(
    input  logic          vsync,
    input  logic          reset_ah,

    // keyboard reports from the usb side
    input  keycode_word_t keycode_i,
    input  logic          keycode_stb_i,

    // game status levels
    input  logic          mute_i,
    input  logic          game_won_i,
    input  logic          game_lost_i,

    output player_keys_t  keys_o,
    output audio_sel_t    audio_sel_o,
    output play_time_t    time_o,
    output logic          time_stb_o
);

    play_time_t play_time;
    logic       tick_stb;
    logic       time_out;

    // -------------------------------------------------------------------------
    // input side
    // -------------------------------------------------------------------------

    key_arbiter key_arbiter_i (
        .vsync         (vsync),
        .reset_ah      (reset_ah),
        .keycode_i     (keycode_i),
        .keycode_stb_i (keycode_stb_i),
        .keys_o        (keys_o)
    );

    // -------------------------------------------------------------------------
    // play timer
    // -------------------------------------------------------------------------

    play_timer #(
        .FRAMES_PER_SEC (FRAMES_PER_SEC),
        .MINUTES_LIMIT  (MINUTES_LIMIT)
    ) play_timer_i (
        .vsync       (vsync),
        .reset_ah    (reset_ah),
        .play_time_o (play_time),
        .tick_stb_o  (tick_stb),
        .time_out_o  (time_out)
    );

    // -------------------------------------------------------------------------
    // output side
    // -------------------------------------------------------------------------

    sound_select sound_select_i (
        .vsync       (vsync),
        .reset_ah    (reset_ah),
        .mute_i      (mute_i),
        .game_won_i  (game_won_i),
        .game_lost_i (game_lost_i),
        .time_out_i  (time_out),
        .play_time_i (play_time),
        .tick_stb_i  (tick_stb),
        .audio_sel_o (audio_sel_o),
        .time_o      (time_o),
        .time_stb_o  (time_stb_o)
    );

endmodule

`default_nettype wire

// ==== logic/sound_select.sv ====
`default_nettype none

module sound_select
    import fbwg_pkg::*;
(
    input  logic       vsync,
    input  logic       reset_ah,
    input  logic       mute_i,
    input  logic       game_won_i,
    input  logic       game_lost_i,
    input  logic       time_out_i,
    input  play_time_t play_time_i,
    input  logic       tick_stb_i,
    output audio_sel_t audio_sel_o,
    output play_time_t time_o,
    output logic       time_stb_o
);

    logic       game_failed;
    audio_sel_t audio_next;

    // -------------------------------------------------------------------------
    // audio source priority
    // -------------------------------------------------------------------------

    // player death comes in on game_lost_i, running out of time is the other cause
    assign game_failed = game_lost_i || time_out_i;

    // mute beats everything, a win beats a loss
    always_comb
    begin
        if (mute_i)
        begin
            audio_next = AUDIO_MUTE;
        end
        else if (game_won_i)
        begin
            audio_next = AUDIO_WIN;
        end
        else if (game_failed)
        begin
            audio_next = AUDIO_FAIL;
        end
        else
        begin
            audio_next = AUDIO_BGM;
        end
    end

    // -------------------------------------------------------------------------
    // output registers
    // -------------------------------------------------------------------------

    always_ff @(posedge vsync)
    begin
        if (reset_ah)
        begin
            audio_sel_o <= AUDIO_BGM;
            time_o      <= '0;
            time_stb_o  <= 1'b0;
        end
        else
        begin
            audio_sel_o <= audio_next;
            time_stb_o  <= tick_stb_i;
            // time only moves with its strobe
            if (tick_stb_i)
            begin
                time_o <= play_time_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/play_timer.sv ====
`default_nettype none

module play_timer
    import fbwg_pkg::*;
#(
    parameter int unsigned FRAMES_PER_SEC = 61,
    parameter int unsigned MINUTES_LIMIT  = 5
)
(
    input  logic       vsync,
    input  logic       reset_ah,
    output play_time_t play_time_o,
    output logic       tick_stb_o,
    output logic       time_out_o
);

    // prescaler sized for the reload value, at least one bit
    localparam int unsigned FRAME_W = (FRAMES_PER_SEC > 1) ? $clog2(FRAMES_PER_SEC) : 1;

    typedef logic [FRAME_W-1:0] frame_cnt_t;

    localparam frame_cnt_t FRAME_RELOAD = frame_cnt_t'(FRAMES_PER_SEC - 1);

    // digit limits
    localparam digit_t UNITS_MAX   = 4'd9;
    localparam digit_t TENS_MAX    = 4'd5;
    localparam digit_t LAST_MINUTE = digit_t'(MINUTES_LIMIT - 1);

    frame_cnt_t   frame_cnt;
    logic         second_done;
    play_time_t   time_q;
    play_time_t   time_d;
    timer_state_t state_q;
    timer_state_t state_d;

    // -------------------------------------------------------------------------
    // frame prescaler
    // -------------------------------------------------------------------------

    // one vsync edge per frame, FRAMES_PER_SEC edges per second
    always_ff @(posedge vsync)
    begin
        if (reset_ah)
        begin
            frame_cnt <= FRAME_RELOAD;
        end
        else if (state_q == TMR_RUN)
        begin
            if (frame_cnt == '0)
            begin
                frame_cnt <= FRAME_RELOAD;
            end
            else
            begin
                frame_cnt <= frame_cnt - 1'b1;
            end
        end
    end

    assign second_done = (frame_cnt == '0) && (state_q == TMR_RUN);

    // -------------------------------------------------------------------------
    // bcd cascade and expiry
    // -------------------------------------------------------------------------

    always_comb
    begin
        time_d  = time_q;
        state_d = state_q;

        if (second_done)
        begin
            if (time_q.units != UNITS_MAX)
            begin
                time_d.units = time_q.units + 1'b1;
            end
            else
            begin
                time_d.units = '0;
                if (time_q.tens != TENS_MAX)
                begin
                    time_d.tens = time_q.tens + 1'b1;
                end
                else
                begin
                    time_d.tens = '0;
                    if (time_q.minutes != LAST_MINUTE)
                    begin
                        time_d.minutes = time_q.minutes + 1'b1;
                    end
                    else
                    begin
                        // limit reached, shows 0:00 and stays there
                        time_d.minutes = '0;
                        state_d        = TMR_EXPIRED;
                    end
                end
            end
        end
    end

    // strobe lines up with the new time value
    always_ff @(posedge vsync)
    begin
        if (reset_ah)
        begin
            time_q     <= '0;
            state_q    <= TMR_RUN;
            tick_stb_o <= 1'b0;
        end
        else
        begin
            time_q     <= time_d;
            state_q    <= state_d;
            tick_stb_o <= second_done;
        end
    end

    assign play_time_o = time_q;
    assign time_out_o  = (state_q == TMR_EXPIRED);

endmodule

`default_nettype wire

// ==== logic/key_arbiter.sv ====
`default_nettype none

module key_arbiter
    import fbwg_pkg::*;
(
    input  logic          vsync,
    input  logic          reset_ah,
    input  keycode_word_t keycode_i,
    input  logic          keycode_stb_i,
    output player_keys_t  keys_o
);

    // report split into key slots, slot 0 holds the top byte
    key_t         key_slot [0:3];
    player_keys_t keys_next;

    // -------------------------------------------------------------------------
    // key classes
    // -------------------------------------------------------------------------

    function automatic logic is_water_key(input key_t key);
        return (key == KEY_W) || (key == KEY_S) ||
               (key == KEY_A) || (key == KEY_D);
    endfunction

    function automatic logic is_fire_key(input key_t key);
        return (key == KEY_UP)   || (key == KEY_DOWN) ||
               (key == KEY_LEFT) || (key == KEY_RIGHT);
    endfunction

    // -------------------------------------------------------------------------
    // first match per player
    // -------------------------------------------------------------------------

    always_comb
    begin
        for (int s = 0; s < 4; s++)
        begin
            key_slot[s] = keycode_i[31 - 8*s -: 8];
        end
    end

    // scan from the last slot up, so an earlier slot overwrites a later one
    // and the top byte wins
    always_comb
    begin
        keys_next.water = KEY_NONE;
        keys_next.fire  = KEY_NONE;

        for (int s = 3; s >= 0; s--)
        begin
            if (is_water_key(key_slot[s]))
            begin
                keys_next.water = key_slot[s];
            end

            // independent of the water search
            if (is_fire_key(key_slot[s]))
            begin
                keys_next.fire = key_slot[s];
            end
        end
    end

    // -------------------------------------------------------------------------
    // output register
    // -------------------------------------------------------------------------

    // only a new report changes the keys, otherwise they hold
    always_ff @(posedge vsync)
    begin
        if (reset_ah)
        begin
            keys_o.water <= KEY_NONE;
            keys_o.fire  <= KEY_NONE;
        end
        else if (keycode_stb_i)
        begin
            keys_o <= keys_next;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fbwg_pkg.sv ====
`default_nettype none

package fbwg_pkg;

    // -------------------------------------------------------------------------
    // base widths
    // -------------------------------------------------------------------------

    // usb hid keycode, one byte per key
    typedef logic [7:0] key_t;

    // one keyboard report, first key in the top byte
    typedef logic [31:0] keycode_word_t;

    // one bcd digit of the play time
    typedef logic [3:0] digit_t;

    // audio source code toward the sound players
    typedef logic [1:0] audio_sel_t;

    // -------------------------------------------------------------------------
    // grouped signals
    // -------------------------------------------------------------------------

    typedef struct packed {
        key_t water;
        key_t fire;
    } player_keys_t;

    // displayed as m:tu
    typedef struct packed {
        digit_t minutes;
        digit_t tens;
        digit_t units;
    } play_time_t;

    typedef enum logic {
        TMR_RUN     = 1'b0,
        TMR_EXPIRED = 1'b1
    } timer_state_t;

    // -------------------------------------------------------------------------
    // keycodes
    // -------------------------------------------------------------------------

    localparam key_t KEY_NONE  = 8'h00;

    // watergirl moves with wasd
    localparam key_t KEY_W     = 8'h1A;
    localparam key_t KEY_S     = 8'h16;
    localparam key_t KEY_A     = 8'h04;
    localparam key_t KEY_D     = 8'h07;

    // fireboy moves with the arrow keys
    localparam key_t KEY_UP    = 8'h52;
    localparam key_t KEY_DOWN  = 8'h51;
    localparam key_t KEY_LEFT  = 8'h50;
    localparam key_t KEY_RIGHT = 8'h4F;

    // audio source codes
    localparam audio_sel_t AUDIO_BGM  = 2'd0;
    localparam audio_sel_t AUDIO_FAIL = 2'd1;
    localparam audio_sel_t AUDIO_WIN  = 2'd2;
    localparam audio_sel_t AUDIO_MUTE = 2'd3;

endpackage

`default_nettype wire
